// ==== isa_pkg.sv ====
// Instruction set definitions for the 16-bit pipeline; stages pull them in with a wildcard import
`default_nettype none

package isa_pkg;

	// One data or address word
	typedef logic [15:0] word_t;

	// Register number, sixteen registers
	typedef logic [3:0] reg_index_t;

	// Opcodes, taken from bits 15..12
	typedef enum logic [3:0] {
		OPCODE_ADD    = 4'h0,
		OPCODE_SUB    = 4'h1,
		OPCODE_RED    = 4'h2,
		OPCODE_XOR    = 4'h3,
		OPCODE_SLL    = 4'h4,
		OPCODE_SRA    = 4'h5,
		OPCODE_ROR    = 4'h6,
		OPCODE_PADDSB = 4'h7,
		OPCODE_LW     = 4'h8,
		OPCODE_SW     = 4'h9,
		OPCODE_LHB    = 4'hA,
		OPCODE_LLB    = 4'hB,
		OPCODE_B      = 4'hC,
		OPCODE_BR     = 4'hD,
		OPCODE_PCS    = 4'hE,
		OPCODE_HLT    = 4'hF
	} opcode_t;

	// Branch conditions, bits 11..9 of B and BR
	typedef enum logic [2:0] {
		COND_NE       = 3'd0,
		COND_EQ       = 3'd1,
		COND_GT       = 3'd2,
		COND_LT       = 3'd3,
		COND_GE       = 3'd4,
		COND_LE       = 3'd5,
		COND_OVERFLOW = 3'd6,
		COND_ALWAYS   = 3'd7
	} cond_t;

	// Flags kept in execute
	typedef struct packed {
		logic zero;
		logic overflow;
		logic negative;
	} alu_flags_t;

	////////////////////////////////////////
	// Instruction field positions
	////////////////////////////////////////

	localparam int OPCODE_LSB = 12;
	localparam int DEST_LSB = 8;
	localparam int SRC1_LSB = 4;
	// Second source and 4-bit immediate share this field
	localparam int SRC2_LSB = 0;
	localparam int COND_LSB = 9;
	// Word offset of B, starts at bit 0
	localparam int OFFSET_WIDTH = 9;

	// Opcodes that end with a register write
	function automatic logic writes_reg(opcode_t opcode);
		case (opcode)
			OPCODE_ADD, OPCODE_SUB, OPCODE_XOR, OPCODE_SLL, OPCODE_SRA: return 1'b1;
			OPCODE_LW, OPCODE_LHB, OPCODE_LLB, OPCODE_PCS: return 1'b1;
			// Unsupported ops pass through as no-ops
			OPCODE_RED, OPCODE_ROR, OPCODE_PADDSB: return 1'b0;
			default: return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== pipe_pkg.sv ====
// Payload structs carried between pipeline stages and to the data memory port
`default_nettype none

package pipe_pkg;

	// Fetch to decode
	typedef struct packed {
		logic valid;
		isa_pkg::word_t instruction;
		isa_pkg::word_t pc_plus_two;
	} if_id_t;

	// Decode to execute, sources already forwarded
	typedef struct packed {
		logic valid;
		isa_pkg::word_t instruction;
		isa_pkg::word_t pc_plus_two;
		isa_pkg::word_t src_data_1;
		isa_pkg::word_t src_data_2;
	} id_ex_t;

	// Execute to memory
	typedef struct packed {
		logic valid;
		isa_pkg::opcode_t opcode;
		isa_pkg::reg_index_t dest_reg;
		isa_pkg::word_t result;
		// Register value stored by SW
		isa_pkg::word_t store_data;
	} ex_mem_t;

	// Memory to writeback
	typedef struct packed {
		logic valid;
		isa_pkg::opcode_t opcode;
		isa_pkg::reg_index_t dest_reg;
		isa_pkg::word_t write_value;
	} mem_wb_t;

	// Data memory request, single cycle
	typedef struct packed {
		isa_pkg::word_t addr;
		isa_pkg::word_t wdata;
		logic rd;
		logic wr;
	} dmem_req_t;

	// Register write, also used for forwarding
	typedef struct packed {
		logic en;
		isa_pkg::reg_index_t dest_reg;
		isa_pkg::word_t value;
	} reg_write_t;

endpackage

`default_nettype wire

// ==== pipeline_register.sv ====
// Stage register with hold and flush, instantiated once per stage with its payload type
`timescale 1ns/1ps
`default_nettype none

module pipeline_register #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic reset,
	input logic hold,
	input logic flush,
	input payload_t d,
	output payload_t q
);

	// Reset first, then flush, then hold
	always_ff @(posedge clk) begin
		if (reset) begin
			q <= '0;
		end else if (flush) begin
			// All-zero payload is a bubble, valid low
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
// Fetch stage holding the PC; drives the instruction address and hands the word to decode
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
	parameter isa_pkg::word_t reset_pc = '0
) (
	input logic clk,
	input logic reset,
	input isa_pkg::word_t imem_data,
	input logic issue_hold,
	input logic redirect,
	input isa_pkg::word_t redirect_pc,
	output isa_pkg::word_t pc,
	output pipe_pkg::if_id_t if_out
);
	import isa_pkg::*;

	word_t pc_plus_two;
	logic halt_fetched;

	assign pc_plus_two = pc + 16'd2;

	// A fetched HLT parks the PC on itself
	assign halt_fetched = opcode_t'(imem_data[OPCODE_LSB +: 4]) == OPCODE_HLT;

	// Redirect beats both the issue hold and the halt stop
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (!(issue_hold || halt_fetched)) begin
			pc <= pc_plus_two;
		end
	end

	// Word fetched in the redirect cycle is on the wrong path
	assign if_out.valid = ~redirect;
	assign if_out.instruction = imem_data;
	assign if_out.pc_plus_two = pc_plus_two;

endmodule

`default_nettype wire

// ==== register_file.sv ====
// Sixteen-word register file for decode, with write-through and a hardwired zero register
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input logic clk,
	input logic reset,
	input isa_pkg::reg_index_t src_reg_1,
	input isa_pkg::reg_index_t src_reg_2,
	input pipe_pkg::reg_write_t write,
	output isa_pkg::word_t src_data_1,
	output isa_pkg::word_t src_data_2
);
	import isa_pkg::*;

	word_t regs [16];

	// Writes to register 0 are dropped
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (write.en && write.dest_reg != '0) begin
			regs[write.dest_reg] <= write.value;
		end
	end

	// Register 0 first, then same-cycle write, then array
	function automatic word_t read_port(reg_index_t src);
		if (src == '0) begin
			return '0;
		end
		if (write.en && write.dest_reg == src) begin
			return write.value;
		end
		return regs[src];
	endfunction

	assign src_data_1 = read_port(src_reg_1);
	assign src_data_2 = read_port(src_reg_2);

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
// Decode stage: IF/ID register, register read with forwarding, and the ID/EX register
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input logic clk,
	input logic reset,
	input pipe_pkg::if_id_t if_in,
	input logic issue_hold,
	input logic redirect,
	input pipe_pkg::reg_write_t ex_fwd,
	input pipe_pkg::reg_write_t mem_fwd,
	input pipe_pkg::reg_write_t wb_write,
	output pipe_pkg::id_ex_t id_ex
);
	import isa_pkg::*;
	import pipe_pkg::*;

	if_id_t if_id;
	id_ex_t id_ex_d;
	opcode_t opcode;
	reg_index_t src_reg_1;
	reg_index_t src_reg_2;
	word_t reg_data_1;
	word_t reg_data_2;

	// Holds behind a B, BR or LW; a taken branch flushes it
	pipeline_register #(.payload_t(if_id_t)) if_id_register (
		.clk   (clk),
		.reset (reset),
		.hold  (issue_hold),
		.flush (redirect),
		.d     (if_in),
		.q     (if_id)
	);

	assign opcode = opcode_t'(if_id.instruction[OPCODE_LSB +: 4]);
	assign src_reg_1 = if_id.instruction[SRC1_LSB +: 4];

	// SW stores and LHB/LLB merge into the destination field register
	assign src_reg_2 = (opcode inside {OPCODE_SW, OPCODE_LHB, OPCODE_LLB}) ?
		if_id.instruction[DEST_LSB +: 4] : if_id.instruction[SRC2_LSB +: 4];

	register_file register_file_unit (
		.clk        (clk),
		.reset      (reset),
		.src_reg_1  (src_reg_1),
		.src_reg_2  (src_reg_2),
		.write      (wb_write),
		.src_data_1 (reg_data_1),
		.src_data_2 (reg_data_2)
	);

	// Youngest producer wins; nothing forwards into register 0
	function automatic word_t forward(reg_index_t src, word_t reg_data);
		if (src != '0 && ex_fwd.en && ex_fwd.dest_reg == src) begin
			return ex_fwd.value;
		end
		if (src != '0 && mem_fwd.en && mem_fwd.dest_reg == src) begin
			return mem_fwd.value;
		end
		return reg_data;
	endfunction

	assign id_ex_d.valid = if_id.valid;
	assign id_ex_d.instruction = if_id.instruction;
	assign id_ex_d.pc_plus_two = if_id.pc_plus_two;
	assign id_ex_d.src_data_1 = forward(src_reg_1, reg_data_1);
	assign id_ex_d.src_data_2 = forward(src_reg_2, reg_data_2);

	// Bubble goes in while execute resolves a B, BR or LW
	pipeline_register #(.payload_t(id_ex_t)) id_ex_register (
		.clk   (clk),
		.reset (reset),
		.hold  (1'b0),
		.flush (issue_hold),
		.d     (id_ex_d),
		.q     (id_ex)
	);

endmodule

`default_nettype wire

// ==== alu.sv ====
// Combinational ALU for execute: add, subtract, xor, shifts and load/store address
`timescale 1ns/1ps
`default_nettype none

module alu (
	input isa_pkg::opcode_t opcode,
	input isa_pkg::word_t a,
	input isa_pkg::word_t b,
	input logic [3:0] imm,
	output isa_pkg::word_t result,
	output isa_pkg::alu_flags_t flags
);
	import isa_pkg::*;

	word_t sum;
	word_t diff;
	word_t mem_offset;
	logic add_overflow;
	logic sub_overflow;

	assign sum = a + b;
	assign diff = a - b;

	// Signed overflow, both wrap around
	assign add_overflow = (a[15] == b[15]) && (sum[15] != a[15]);
	assign sub_overflow = (a[15] != b[15]) && (diff[15] != a[15]);

	// Immediate counts words, so doubled and sign extended
	assign mem_offset = {{11{imm[3]}}, imm, 1'b0};

	always_comb begin
		case (opcode)
			OPCODE_ADD: result = sum;
			OPCODE_SUB: result = diff;
			OPCODE_XOR: result = a ^ b;
			OPCODE_SLL: result = a << imm;
			OPCODE_SRA: result = $signed(a) >>> imm;
			// Base is word aligned before the offset is added
			OPCODE_LW, OPCODE_SW: result = {a[15:1], 1'b0} + mem_offset;
			default: result = '0;
		endcase
	end

	// Execute decides which of these the opcode may update
	assign flags.zero = (result == '0);
	assign flags.overflow = (opcode == OPCODE_SUB) ? sub_overflow : add_overflow;
	assign flags.negative = result[15];

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
// Execute stage: ALU, result select, flags, branch resolution and the EX/MEM register
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input logic clk,
	input logic reset,
	input pipe_pkg::id_ex_t id_ex,
	output logic issue_hold,
	output logic redirect,
	output isa_pkg::word_t redirect_pc,
	output pipe_pkg::reg_write_t ex_fwd,
	output pipe_pkg::ex_mem_t ex_mem
);
	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_t opcode;
	reg_index_t dest_reg;
	word_t alu_result;
	word_t result;
	word_t branch_target;
	alu_flags_t alu_flags;
	alu_flags_t flags_q;
	cond_t cond;
	logic cond_true;
	logic is_branch;
	ex_mem_t ex_mem_d;

	assign opcode = opcode_t'(id_ex.instruction[OPCODE_LSB +: 4]);
	assign dest_reg = id_ex.instruction[DEST_LSB +: 4];

	alu alu_unit (
		.opcode (opcode),
		.a      (id_ex.src_data_1),
		.b      (id_ex.src_data_2),
		.imm    (id_ex.instruction[SRC2_LSB +: 4]),
		.result (alu_result),
		.flags  (alu_flags)
	);

	// Byte loads keep the other byte of the old destination
	always_comb begin
		case (opcode)
			OPCODE_LHB: result = {id_ex.instruction[7:0], id_ex.src_data_2[7:0]};
			OPCODE_LLB: result = {id_ex.src_data_2[15:8], id_ex.instruction[7:0]};
			OPCODE_PCS: result = id_ex.pc_plus_two;
			default: result = alu_result;
		endcase
	end

	////////////////////////////////////////
	// Flags register
	////////////////////////////////////////

	// ADD and SUB set all flags, logic and shifts only zero
	always_ff @(posedge clk) begin
		if (reset) begin
			flags_q <= '0;
		end else if (id_ex.valid && opcode inside {OPCODE_ADD, OPCODE_SUB}) begin
			flags_q <= alu_flags;
		end else if (id_ex.valid && opcode inside {OPCODE_XOR, OPCODE_SLL, OPCODE_SRA}) begin
			flags_q.zero <= alu_flags.zero;
		end
	end

	////////////////////////////////////////
	// Branch resolution
	////////////////////////////////////////

	assign cond = cond_t'(id_ex.instruction[COND_LSB +: 3]);

	always_comb begin
		case (cond)
			COND_NE: cond_true = ~flags_q.zero;
			COND_EQ: cond_true = flags_q.zero;
			COND_GT: cond_true = ~flags_q.zero & ~flags_q.negative;
			COND_LT: cond_true = flags_q.negative;
			COND_GE: cond_true = flags_q.zero | ~flags_q.negative;
			COND_LE: cond_true = flags_q.zero | flags_q.negative;
			COND_OVERFLOW: cond_true = flags_q.overflow;
			COND_ALWAYS: cond_true = 1'b1;
			default: cond_true = 1'b0;
		endcase
	end

	// Signed word offset from PC+2
	assign branch_target = id_ex.pc_plus_two + {{(15 - OFFSET_WIDTH){id_ex.instruction[OFFSET_WIDTH - 1]}},
		id_ex.instruction[OFFSET_WIDTH - 1:0], 1'b0};

	assign is_branch = opcode inside {OPCODE_B, OPCODE_BR};
	assign issue_hold = id_ex.valid && (is_branch || opcode == OPCODE_LW);
	assign redirect = id_ex.valid && is_branch && cond_true;
	assign redirect_pc = (opcode == OPCODE_BR) ? id_ex.src_data_1 : branch_target;

	// Load data is not known yet, LW forwards from memory instead
	assign ex_fwd.en = id_ex.valid && writes_reg(opcode) && opcode != OPCODE_LW;
	assign ex_fwd.dest_reg = dest_reg;
	assign ex_fwd.value = result;

	assign ex_mem_d.valid = id_ex.valid;
	assign ex_mem_d.opcode = opcode;
	assign ex_mem_d.dest_reg = dest_reg;
	assign ex_mem_d.result = result;
	assign ex_mem_d.store_data = id_ex.src_data_2;

	pipeline_register #(.payload_t(ex_mem_t)) ex_mem_register (
		.clk   (clk),
		.reset (reset),
		.hold  (1'b0),
		.flush (1'b0),
		.d     (ex_mem_d),
		.q     (ex_mem)
	);

endmodule

`default_nettype wire

// ==== memory_writeback_stage.sv ====
// Memory and writeback stages: data memory access, MEM/WB register, register write and halt
`timescale 1ns/1ps
`default_nettype none

module memory_writeback_stage (
	input logic clk,
	input logic reset,
	input pipe_pkg::ex_mem_t ex_mem,
	input isa_pkg::word_t dmem_rdata,
	output pipe_pkg::dmem_req_t dmem_req,
	output pipe_pkg::reg_write_t mem_fwd,
	output pipe_pkg::reg_write_t wb_write,
	output logic hlt
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t write_value;
	mem_wb_t mem_wb_d;
	mem_wb_t mem_wb;
	logic hlt_q;

	// ALU result doubles as the address
	assign dmem_req.addr = ex_mem.result;
	assign dmem_req.wdata = ex_mem.store_data;
	assign dmem_req.rd = ex_mem.valid && ex_mem.opcode == OPCODE_LW;
	assign dmem_req.wr = ex_mem.valid && ex_mem.opcode == OPCODE_SW;

	// Read data arrives in the same cycle
	assign write_value = (ex_mem.opcode == OPCODE_LW) ? dmem_rdata : ex_mem.result;

	assign mem_fwd.en = ex_mem.valid && writes_reg(ex_mem.opcode);
	assign mem_fwd.dest_reg = ex_mem.dest_reg;
	assign mem_fwd.value = write_value;

	assign mem_wb_d.valid = ex_mem.valid;
	assign mem_wb_d.opcode = ex_mem.opcode;
	assign mem_wb_d.dest_reg = ex_mem.dest_reg;
	assign mem_wb_d.write_value = write_value;

	pipeline_register #(.payload_t(mem_wb_t)) mem_wb_register (
		.clk   (clk),
		.reset (reset),
		.hold  (1'b0),
		.flush (1'b0),
		.d     (mem_wb_d),
		.q     (mem_wb)
	);

	////////////////////////////////////////
	// Writeback
	////////////////////////////////////////

	assign wb_write.en = mem_wb.valid && writes_reg(mem_wb.opcode);
	assign wb_write.dest_reg = mem_wb.dest_reg;
	assign wb_write.value = mem_wb.write_value;

	// Rises as HLT lands in writeback, then latched
	assign hlt = hlt_q | (mem_wb.valid && mem_wb.opcode == OPCODE_HLT);

	always_ff @(posedge clk) begin
		if (reset) begin
			hlt_q <= 1'b0;
		end else begin
			hlt_q <= hlt;
		end
	end

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
// Top level of the five-stage CPU, connecting the stages to instruction and data memory ports
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter isa_pkg::word_t reset_pc = '0
) (
	input logic clk,
	input logic reset,
	output isa_pkg::word_t imem_addr,
	input isa_pkg::word_t imem_data,
	output pipe_pkg::dmem_req_t dmem_req,
	input isa_pkg::word_t dmem_rdata,
	output logic hlt
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// Forward path between stages
	if_id_t if_out;
	id_ex_t id_ex;
	ex_mem_t ex_mem;

	// Control and data flowing back from execute and writeback
	logic issue_hold;
	logic redirect;
	word_t redirect_pc;
	reg_write_t ex_fwd;
	reg_write_t mem_fwd;
	reg_write_t wb_write;

	////////////////////////////////////////
	// Stages
	////////////////////////////////////////

	// PC goes straight out as the instruction address
	fetch_stage #(.reset_pc(reset_pc)) fetch (
		.clk         (clk),
		.reset       (reset),
		.imem_data   (imem_data),
		.issue_hold  (issue_hold),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.pc          (imem_addr),
		.if_out      (if_out)
	);

	decode_stage decode (
		.clk        (clk),
		.reset      (reset),
		.if_in      (if_out),
		.issue_hold (issue_hold),
		.redirect   (redirect),
		.ex_fwd     (ex_fwd),
		.mem_fwd    (mem_fwd),
		.wb_write   (wb_write),
		.id_ex      (id_ex)
	);

	execute_stage execute (
		.clk         (clk),
		.reset       (reset),
		.id_ex       (id_ex),
		.issue_hold  (issue_hold),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.ex_fwd      (ex_fwd),
		.ex_mem      (ex_mem)
	);

	memory_writeback_stage memory_writeback (
		.clk        (clk),
		.reset      (reset),
		.ex_mem     (ex_mem),
		.dmem_rdata (dmem_rdata),
		.dmem_req   (dmem_req),
		.mem_fwd    (mem_fwd),
		.wb_write   (wb_write),
		.hlt        (hlt)
	);

endmodule

`default_nettype wire

// ==== cpu_properties.sv ====
// Concurrent checks on the CPU ports, bound into every cpu_top instance
`timescale 1ns/1ps
`default_nettype none

module cpu_properties (
	input logic clk,
	input logic reset,
	input logic hlt,
	input pipe_pkg::dmem_req_t dmem_req,
	input isa_pkg::word_t pc
);

	// Single-port data memory
	assert property (@(posedge clk) disable iff (reset) !(dmem_req.rd && dmem_req.wr))
		else $error("dmem_req.rd and dmem_req.wr high together");

	// Halt is sticky
	assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
		else $error("hlt fell without reset");

	// Fetch frozen once halted
	assert property (@(posedge clk) disable iff (reset) hlt |=> $stable(pc))
		else $error("pc moved while hlt was high");

	assert property (@(posedge clk) reset |=> !hlt)
		else $error("hlt high right after reset");

endmodule

bind cpu_top cpu_properties properties_unit (
	.clk      (clk),
	.reset    (reset),
	.hlt      (hlt),
	.dmem_req (dmem_req),
	.pc       (imem_addr)
);

`default_nettype wire

// ==== tb_cpu.sv ====
// Directed testbench for cpu_top; builds small programs, runs them to HLT and checks the stores
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLES_PER_TASK = 300;
	localparam int TASK_COUNT = 6;
	localparam int WATCHDOG_NS = TASK_COUNT * (CYCLES_PER_TASK + RESET_CYCLES) * CLK_PERIOD;

	logic clk;
	logic reset;
	word_t imem_addr;
	word_t imem_data;
	word_t dmem_rdata;
	dmem_req_t dmem_req;
	logic hlt;

	// Byte addressed, one word per even address
	word_t imem [256];
	word_t dmem [256];
	int prog_len;
	logic [31:0] rng_state;

	// Observed and predicted stores, in order
	word_t log_addr [$];
	word_t log_data [$];
	word_t exp_addr [$];
	word_t exp_data [$];

	// Observed and predicted load addresses, in order
	word_t log_load_addr [$];
	word_t exp_load_addr [$];

	cpu_top #(.reset_pc(16'h0000)) uut (
		.clk        (clk),
		.reset      (reset),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_req   (dmem_req),
		.dmem_rdata (dmem_rdata),
		.hlt        (hlt)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////
	// Memory models
	////////////////////////////////////////

	// Both reads are combinational
	assign imem_data = imem[imem_addr[8:1]];
	assign dmem_rdata = dmem[dmem_req.addr[8:1]];

	// Store lands at the rising edge and goes to the log
	always @(posedge clk) begin
		if (!reset && dmem_req.wr) begin
			dmem[dmem_req.addr[8:1]] <= dmem_req.wdata;
			log_addr.push_back(dmem_req.addr);
			log_data.push_back(dmem_req.wdata);
		end
		// Every read strobe is logged with its address
		if (!reset && dmem_req.rd) begin
			log_load_addr.push_back(dmem_req.addr);
		end
	end

	// Background data, every index gives its own word
	function automatic word_t fill_word(int index);
		return 16'(index * 40503) ^ 16'h5a3c;
	endfunction

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t next_random();
		rng_state = xorshift32(rng_state);
		return rng_state[15:0];
	endfunction

	////////////////////////////////////////
	// Instruction encoders
	////////////////////////////////////////

	function automatic word_t enc_r(opcode_t op, reg_index_t rd, reg_index_t rs, logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic word_t enc_byte(opcode_t op, reg_index_t rd, logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic word_t enc_b(cond_t cond, logic [8:0] offset);
		return {OPCODE_B, cond, offset};
	endfunction

	function automatic word_t enc_br(cond_t cond, reg_index_t rs);
		return {OPCODE_BR, cond, 1'b0, rs, 4'h0};
	endfunction

	// Condition rules on zero, overflow and negative
	function automatic logic cond_holds(int cond, logic z, logic v, logic n);
		case (cond)
			0: return !z;
			1: return z;
			2: return !z && !n;
			3: return n;
			4: return z || !n;
			5: return z || n;
			6: return v;
			default: return 1'b1;
		endcase
	endfunction

	task automatic emit(word_t word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	// Full 16-bit constant, low byte then high byte
	task automatic emit_load(reg_index_t rd, word_t value);
		emit(enc_byte(OPCODE_LLB, rd, value[7:0]));
		emit(enc_byte(OPCODE_LHB, rd, value[15:8]));
	endtask

	task automatic expect_store(word_t addr, word_t data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic expect_load(word_t addr);
		exp_load_addr.push_back(addr);
	endtask

	////////////////////////////////////////
	// Reporting
	////////////////////////////////////////

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
		report_failure($sformatf("Mismatch at %0t: %s got 'h%0h expected 'h%0h",
			$time, name, got, want));
	endtask

	////////////////////////////////////////
	// Run control
	////////////////////////////////////////

	// Empty program memory halts, data memory gets its pattern
	task automatic new_program();
		for (int i = 0; i < 256; i++) begin
			imem[i] = {OPCODE_HLT, 12'h000};
			dmem[i] = fill_word(i);
		end
		prog_len = 0;
		exp_addr.delete();
		exp_data.delete();
		exp_load_addr.delete();
	endtask

	task automatic run_program();
		@(negedge clk);
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		log_addr.delete();
		log_data.delete();
		log_load_addr.delete();
		reset = 1'b0;
		while (!hlt) @(negedge clk);
	endtask

	task automatic check_memory_log(string test_name);
		assert (log_addr.size() == exp_addr.size()) else
			report_mismatch({test_name, " store count"}, log_addr.size(), exp_addr.size());
		for (int i = 0; i < exp_addr.size(); i++) begin
			assert (log_addr[i] == exp_addr[i]) else
				report_mismatch({test_name, " dmem_req.addr"}, log_addr[i], exp_addr[i]);
			assert (log_data[i] == exp_data[i]) else
				report_mismatch({test_name, " dmem_req.wdata"}, log_data[i], exp_data[i]);
		end
		assert (log_load_addr.size() == exp_load_addr.size()) else
			report_mismatch({test_name, " dmem_req.rd count"}, log_load_addr.size(),
				exp_load_addr.size());
		for (int i = 0; i < exp_load_addr.size(); i++) begin
			assert (log_load_addr[i] == exp_load_addr[i]) else
				report_mismatch({test_name, " dmem_req.addr on read"}, log_load_addr[i],
					exp_load_addr[i]);
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	// Back-to-back dependent ALU ops, each result stored
	task automatic test_alu_chain();
		word_t a, b, r3, r4, r5, r6, r7, r8, r9;
		logic [3:0] s1, s2;
		new_program();
		for (int round = 0; round < 2; round++) begin
			a = next_random();
			b = next_random();
			s1 = 4'(next_random());
			s2 = 4'(next_random());
			r3 = a + b;
			r4 = r3 - a;
			r5 = r4 ^ r3;
			r6 = r5 << s1;
			r7 = $signed(r6) >>> s2;
			r8 = r7 + r6;
			r9 = r8 - r7;
			emit_load(4'd1, a);
			emit_load(4'd2, b);
			emit(enc_r(OPCODE_ADD, 4'd3, 4'd1, 4'd2));
			emit(enc_r(OPCODE_SW, 4'd3, 4'd0, 4'd1));
			emit(enc_r(OPCODE_SUB, 4'd4, 4'd3, 4'd1));
			emit(enc_r(OPCODE_SW, 4'd4, 4'd0, 4'd2));
			emit(enc_r(OPCODE_XOR, 4'd5, 4'd4, 4'd3));
			emit(enc_r(OPCODE_SW, 4'd5, 4'd0, 4'd3));
			emit(enc_r(OPCODE_SLL, 4'd6, 4'd5, s1));
			emit(enc_r(OPCODE_SW, 4'd6, 4'd0, 4'd4));
			emit(enc_r(OPCODE_SRA, 4'd7, 4'd6, s2));
			emit(enc_r(OPCODE_SW, 4'd7, 4'd0, 4'd5));
			// Two consumers in a row, fed from execute and memory
			emit(enc_r(OPCODE_ADD, 4'd8, 4'd7, 4'd6));
			emit(enc_r(OPCODE_SUB, 4'd9, 4'd8, 4'd7));
			emit(enc_r(OPCODE_SW, 4'd8, 4'd0, 4'd6));
			emit(enc_r(OPCODE_SW, 4'd9, 4'd0, 4'd7));
			expect_store(16'd2, r3);
			expect_store(16'd4, r4);
			expect_store(16'd6, r5);
			expect_store(16'd8, r6);
			expect_store(16'd10, r7);
			expect_store(16'd12, r8);
			expect_store(16'd14, r9);
		end
		emit({OPCODE_HLT, 12'h000});
		run_program();
		check_memory_log("alu_chain");
	endtask

	// Store, reload, use at once; then an odd base with negative offset
	task automatic test_load_use();
		word_t v;
		word_t addr;
		new_program();
		v = next_random();
		addr = 16'h0020 - 16'd4;
		emit_load(4'd1, v);
		emit(enc_r(OPCODE_SW, 4'd1, 4'd0, 4'd3));
		emit(enc_r(OPCODE_LW, 4'd2, 4'd0, 4'd3));
		emit(enc_r(OPCODE_ADD, 4'd3, 4'd2, 4'd1));
		emit(enc_r(OPCODE_SW, 4'd3, 4'd0, 4'd4));
		emit(enc_byte(OPCODE_LLB, 4'd4, 8'h21));
		emit(enc_r(OPCODE_LW, 4'd5, 4'd4, 4'he));
		emit(enc_r(OPCODE_SW, 4'd5, 4'd0, 4'd5));
		emit({OPCODE_HLT, 12'h000});
		expect_store(16'd6, v);
		expect_store(16'd8, v + v);
		expect_store(16'd10, fill_word(int'(addr[8:1])));
		expect_load(16'd6);
		expect_load(addr);
		run_program();
		check_memory_log("load_use");
	endtask

	// One flag setup followed by all eight conditions
	task automatic branch_scenario(int scen, logic is_sub, word_t a, word_t b);
		word_t r;
		logic z, v, n;
		int base;
		int exact;
		base = 64 + scen * 16;
		// Exact signed result; overflow when it leaves the 16-bit range
		if (is_sub) begin
			exact = int'($signed(a)) - int'($signed(b));
		end else begin
			exact = int'($signed(a)) + int'($signed(b));
		end
		r = 16'(exact);
		z = (r == 16'h0000);
		n = r[15];
		v = (exact > 32767) || (exact < -32768);
		emit_load(4'd1, a);
		emit_load(4'd2, b);
		emit(enc_byte(OPCODE_LLB, 4'd10, 8'(base)));
		emit(enc_r(is_sub ? OPCODE_SUB : OPCODE_ADD, 4'd3, 4'd1, 4'd2));
		for (int c = 0; c < 8; c++) begin
			// Taken branch skips exactly the store after it
			emit(enc_b(cond_t'(c[2:0]), 9'd1));
			emit(enc_r(OPCODE_SW, 4'd3, 4'd10, c[3:0]));
			if (!cond_holds(c, z, v, n)) begin
				expect_store(16'(base + 2 * c), r);
			end
		end
	endtask

	task automatic test_branch_conditions();
		new_program();
		branch_scenario(0, 1'b0, 16'h7000, 16'h1000);
		branch_scenario(1, 1'b1, 16'h1234, 16'h1234);
		branch_scenario(2, 1'b1, 16'h0005, 16'h0010);
		branch_scenario(3, 1'b0, 16'h0003, 16'h0004);
		emit({OPCODE_HLT, 12'h000});
		run_program();
		check_memory_log("branch_conditions");
	endtask

	// PCS value, then BR to it plus an offset
	task automatic test_pcs_jump();
		word_t pcs_value;
		word_t target;
		new_program();
		pcs_value = 16'd4;
		target = 16'd18;
		emit(enc_byte(OPCODE_LLB, 4'd3, 8'(target - pcs_value)));
		emit(enc_byte(OPCODE_PCS, 4'd1, 8'h00));
		emit(enc_r(OPCODE_SW, 4'd1, 4'd0, 4'd0));
		emit(enc_r(OPCODE_ADD, 4'd2, 4'd1, 4'd3));
		// Sum is nonzero so the equal jump falls through
		emit(enc_br(COND_EQ, 4'd2));
		emit(enc_r(OPCODE_SW, 4'd3, 4'd0, 4'd1));
		emit(enc_br(COND_ALWAYS, 4'd2));
		emit(enc_r(OPCODE_SW, 4'd1, 4'd0, 4'd2));
		emit(enc_r(OPCODE_SW, 4'd1, 4'd0, 4'd3));
		emit(enc_byte(OPCODE_LLB, 4'd4, 8'h5a));
		emit(enc_r(OPCODE_SW, 4'd4, 4'd0, 4'd4));
		emit({OPCODE_HLT, 12'h000});
		expect_store(16'd0, pcs_value);
		expect_store(16'd2, target - pcs_value);
		expect_store(16'd8, 16'h005a);
		run_program();
		check_memory_log("pcs_jump");
	endtask

	// Halt stops fetch; later stores never issue
	task automatic test_halt();
		word_t v;
		word_t hlt_addr;
		new_program();
		v = next_random();
		emit_load(4'd1, v);
		emit(enc_r(OPCODE_SW, 4'd1, 4'd0, 4'd1));
		hlt_addr = 16'(2 * prog_len);
		emit({OPCODE_HLT, 12'h000});
		emit(enc_r(OPCODE_SW, 4'd1, 4'd0, 4'd2));
		emit(enc_r(OPCODE_SW, 4'd1, 4'd0, 4'd3));
		expect_store(16'd2, v);
		run_program();
		repeat (20) begin
			@(negedge clk);
			assert (hlt) else report_failure("hlt dropped while the processor was halted");
			assert (imem_addr == hlt_addr) else report_mismatch("imem_addr", imem_addr, hlt_addr);
		end
		check_memory_log("halt");
	endtask

	// Dropped opcodes touch neither registers nor flags
	task automatic test_dropped_opcodes();
		new_program();
		emit(enc_byte(OPCODE_LLB, 4'd1, 8'h05));
		emit(enc_byte(OPCODE_LLB, 4'd2, 8'h03));
		emit(enc_byte(OPCODE_LLB, 4'd4, 8'h77));
		emit(enc_r(OPCODE_SUB, 4'd3, 4'd1, 4'd2));
		emit(enc_r(OPCODE_RED, 4'd4, 4'd1, 4'd2));
		emit(enc_r(OPCODE_ROR, 4'd4, 4'd1, 4'd3));
		emit(enc_r(OPCODE_PADDSB, 4'd4, 4'd1, 4'd2));
		emit(enc_r(OPCODE_SW, 4'd4, 4'd0, 4'd0));
		// Zero flag from the SUB must still be clear
		emit(enc_b(COND_NE, 9'd1));
		emit(enc_r(OPCODE_SW, 4'd1, 4'd0, 4'd1));
		emit(enc_r(OPCODE_SW, 4'd2, 4'd0, 4'd2));
		emit({OPCODE_HLT, 12'h000});
		expect_store(16'd0, 16'h0077);
		expect_store(16'd4, 16'h0003);
		run_program();
		check_memory_log("dropped_opcodes");
	endtask

	////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		rng_state = 32'd99;
		new_program();
		test_alu_chain();
		test_load_use();
		test_branch_conditions();
		test_pcs_jump();
		test_halt();
		test_dropped_opcodes();
		$display("Simulation completed successfully");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		report_failure("Timeout: a test program never reached HLT");
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
isa_pkg.sv
pipe_pkg.sv
pipeline_register.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
alu.sv
execute_stage.sv
memory_writeback_stage.sv
cpu_top.sv
cpu_properties.sv
tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_cpu -f verilog.f -o sim_tb_cpu &&
./obj_dir/sim_tb_cpu | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "PASS" || { echo "FAIL"; exit 1; }
